/* pa_pkg.sv */
package pa_pkg;

	localparam int word_w = 16;

	// bit 0 is the most significant bit
	typedef logic [0:word_w-1] word_t;

	// W bus sources
	typedef enum logic [2:0] {
		w_ir,
		w_kl,
		w_rdt,
		w_swap,
		w_ki,
		w_at,
		w_ac,
		w_a
	} w_src_t;

	// a_ir puts the L low byte on top of the IR low byte
	typedef enum logic [1:0] {
		a_l,
		a_ar,
		a_ic,
		a_ir
	} a_src_t;

	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_pass_a,
		op_inc_a,
		op_dec_a
	} alu_op_t;

	// source of the bit above bit 0
	typedef enum logic [1:0] {
		ext_minus_one,
		ext_plus_one,
		ext_sum,
		ext_diff
	} ext_t;

	typedef struct packed {
		w_src_t w_sel;
		logic blank_hi;
		logic blank_lo;
		logic w_dt;
		a_src_t a_sel;
		// [0] clears 0..7, [1] clears 8..9, [2] clears 10..15
		logic [0:2] blank_a;
		alu_op_t op;
		logic carry_in;
		ext_t ext;
		logic w_ac;
		logic w_ar;
		logic w_ic;
		logic ar_inc;
		logic ar_step4;
		logic ic_inc;
		logic at_load;
		logic at_shift;
		logic at_sin;
		logic wzi_load;
		logic ar_ad;
		logic ic_ad;
	} pa_ctl_t;

	typedef struct packed {
		logic s0;
		logic carry;
		logic s_1;
		logic zs;
		logic wzi;
		logic arz;
		logic zga;
		logic at15;
		logic exx;
		logic exy;
	} pa_flags_t;

endpackage

/* pa_w_mux.sv */
`timescale 1ns/10ps

module pa_w_mux import pa_pkg::*; (
	input pa_ctl_t ctl,
	input word_t ir,
	input word_t ki,
	input word_t rdt,
	input word_t kl,
	input word_t at,
	input word_t ac,
	input word_t a_bus,
	output word_t w,
	output word_t ddt
);

	word_t src;

	always_comb begin
		case (ctl.w_sel)
			w_ir: src = ir;
			w_kl: src = kl;
			w_rdt: src = rdt;
			// ac bits 0..7 moved down to the 8..15 lane with the upper lane empty
			w_swap: src = {8'h00, ac[0:7]};
			w_ki: src = ki;
			w_at: src = at;
			w_ac: src = ac;
			default: src = a_bus;
		endcase
	end

	// each byte lane blanked on its own
	assign w[0:7] = ctl.blank_hi ? 8'h00 : src[0:7];
	assign w[8:15] = ctl.blank_lo ? 8'h00 : src[8:15];

	// data bus only sees W while w_dt is set
	assign ddt = ctl.w_dt ? w : '0;

endmodule

/* pa_a_mux.sv */
`timescale 1ns/10ps

module pa_a_mux import pa_pkg::*; (
	input pa_ctl_t ctl,
	input word_t ir,
	input word_t l,
	input word_t ar,
	input word_t ic,
	output word_t a_bus
);

	word_t src;

	always_comb begin
		case (ctl.a_sel)
			a_l: src = l;
			a_ar: src = ar;
			a_ic: src = ic;
			// short argument path puts the L byte above the IR offset field
			default: src = {l[8:15], ir[8:15]};
		endcase
	end

	// fields follow the instruction layout
	assign a_bus[0:7] = ctl.blank_a[0] ? 8'h00 : src[0:7];
	assign a_bus[8:9] = ctl.blank_a[1] ? 2'b00 : src[8:9];
	assign a_bus[10:15] = ctl.blank_a[2] ? 6'h00 : src[10:15];

endmodule

/* pa_alu.sv */
`timescale 1ns/10ps

module pa_alu import pa_pkg::*; (
	input alu_op_t op,
	input logic carry_in,
	input word_t a_bus,
	input word_t ac,
	output word_t f,
	output logic carry,
	output logic zsum
);

	localparam logic [word_w:0] one = {{word_w{1'b0}}, 1'b1};
	localparam logic [word_w:0] all_ones = {1'b0, {word_w{1'b1}}};

	// bit word_w holds the carry out
	logic [word_w:0] res;
	logic [word_w:0] a_ext;
	logic [word_w:0] ac_ext;

	assign a_ext = {1'b0, a_bus};
	assign ac_ext = {1'b0, ac};

	always_comb begin
		case (op)
			op_add: res = a_ext + ac_ext + {{word_w{1'b0}}, carry_in};
			// two's complement subtract where carry set means no borrow
			op_sub: res = a_ext + {1'b0, ~ac} + one;
			op_and: res = {1'b0, a_bus & ac};
			op_or: res = {1'b0, a_bus | ac};
			op_xor: res = {1'b0, a_bus ^ ac};
			op_pass_a: res = a_ext;
			op_inc_a: res = a_ext + one;
			// adding all ones leaves carry clear only when a was zero
			default: res = a_ext + all_ones;
		endcase
	end

	assign f = res[word_w-1:0];
	assign carry = res[word_w];
	assign zsum = (f == '0);

endmodule

/* pa_at_reg.sv */
`timescale 1ns/10ps

module pa_at_reg import pa_pkg::*; (
	input logic strob,
	input logic rst,
	input logic at_load,
	input logic at_shift,
	input logic at_sin,
	input word_t f,
	output word_t at,
	output logic at15
);

	always_ff @(posedge strob) begin
		if (rst) begin
			at <= '0;
		end else if (at_load) begin
			at <= f;
		end else if (at_shift) begin
			// shift toward bit 15 with the serial bit entering at bit 0
			at <= {at_sin, at[0:word_w-2]};
		end
	end

	assign at15 = at[word_w-1];

	// control unit never asks for both in one step
	a_load_shift_excl: assert property (
		@(posedge strob) disable iff (rst) !(at_load && at_shift)
	) else $error("at_load and at_shift both set");

endmodule

/* pa_accum.sv */
`timescale 1ns/10ps

module pa_accum import pa_pkg::*; (
	input logic strob,
	input logic rst,
	input logic w_ac,
	input logic wzi_load,
	input ext_t ext,
	input word_t w,
	input word_t a_bus,
	input logic carry,
	input logic zsum,
	output word_t ac,
	output logic s_1,
	output logic zs,
	output logic wzi
);

	logic ext_bit;

	always_ff @(posedge strob) begin
		if (rst) begin
			ac <= '0;
			wzi <= 1'b0;
		end else begin
			if (w_ac) begin
				ac <= w;
			end
			if (wzi_load) begin
				wzi <= zs;
			end
		end
	end

	// sign of the second operand seen one bit above bit 0
	always_comb begin
		case (ext)
			ext_minus_one: ext_bit = ~a_bus[0];
			ext_plus_one: ext_bit = a_bus[0];
			ext_sum: ext_bit = ac[0] ^ a_bus[0];
			default: ext_bit = ~(ac[0] ^ a_bus[0]);
		endcase
	end

	assign s_1 = ext_bit ^ carry;

	// 17-bit zero including the extension bit
	assign zs = zsum & ~s_1;

endmodule

/* pa_addr_regs.sv */
`timescale 1ns/10ps

module pa_addr_regs import pa_pkg::*; (
	input logic strob,
	input logic rst,
	input pa_ctl_t ctl,
	input word_t w,
	input word_t kl,
	output word_t ar,
	output word_t ic,
	output word_t dad,
	output logic arz,
	output logic zga
);

	always_ff @(posedge strob) begin
		if (rst) begin
			ar <= '0;
		end else if (ctl.w_ar) begin
			ar <= w;
		end else if (ctl.ar_step4) begin
			// step back by four words
			ar <= ar - word_w'(4);
		end else if (ctl.ar_inc) begin
			ar <= ar + word_w'(1);
		end
	end

	always_ff @(posedge strob) begin
		if (rst) begin
			ic <= '0;
		end else if (ctl.w_ic) begin
			ic <= w;
		end else if (ctl.ic_inc) begin
			ic <= ic + word_w'(1);
		end
	end

	// both enables OR the two registers onto the bus
	assign dad = ({word_w{ctl.ar_ad}} & ar) | ({word_w{ctl.ic_ad}} & ic);

	// address above the first 256 words
	assign arz = |ar[0:7];

	// front panel key compare
	assign zga = (dad == kl);

	a_ar_step_excl: assert property (
		@(posedge strob) disable iff (rst) !(ctl.ar_inc && ctl.ar_step4)
	) else $error("ar_inc and ar_step4 both set");

endmodule

/* pa_top.sv */
`timescale 1ns/10ps

module pa_top import pa_pkg::*; (
	input logic strob,
	input logic rst,
	input pa_ctl_t ctl,
	input word_t ir,
	input word_t ki,
	input word_t rdt,
	input word_t kl,
	input word_t l,
	input logic exx_sel,
	input logic axy,
	output word_t w,
	output word_t ddt,
	output word_t dad,
	output pa_flags_t flags
);

	word_t a_bus;
	word_t f;
	word_t ac;
	word_t at;
	word_t ar;
	word_t ic;
	logic carry;
	logic zsum;
	logic s_1;
	logic zs;
	logic wzi;
	logic arz;
	logic zga;
	logic at15;

	pa_w_mux i_w_mux (
		.ctl, .ir, .ki, .rdt, .kl, .at, .ac, .a_bus, .w, .ddt
	);

	pa_a_mux i_a_mux (
		.ctl, .ir, .l, .ar, .ic, .a_bus
	);

	pa_alu i_alu (
		.op(ctl.op), .carry_in(ctl.carry_in), .a_bus, .ac, .f, .carry, .zsum
	);

	pa_accum i_accum (
		.strob, .rst, .w_ac(ctl.w_ac), .wzi_load(ctl.wzi_load), .ext(ctl.ext),
		.w, .a_bus, .carry, .zsum, .ac, .s_1, .zs, .wzi
	);

	pa_at_reg i_at_reg (
		.strob, .rst, .at_load(ctl.at_load), .at_shift(ctl.at_shift),
		.at_sin(ctl.at_sin), .f, .at, .at15
	);

	pa_addr_regs i_addr_regs (
		.strob, .rst, .ctl, .w, .kl, .ar, .ic, .dad, .arz, .zga
	);

	// exx picks the A bus end bit, exy the AT tail or A bus head
	assign flags = '{
		s0: f[0],
		carry: carry,
		s_1: s_1,
		zs: zs,
		wzi: wzi,
		arz: arz,
		zga: zga,
		at15: at15,
		exx: exx_sel ? a_bus[word_w-1] : a_bus[0],
		exy: axy ? at[word_w-1] : a_bus[0]
	};

	// flags and AC/AT loads all depend on a defined operation
	a_op_known: assert property (
		@(posedge strob) disable iff (rst) !$isunknown(ctl.op)
	) else $error("alu op unknown");

endmodule

/* tb_pa_model.svh */
`ifndef TB_PA_MODEL_SVH
`define TB_PA_MODEL_SVH

// mirrored registers in numeric bit order with bit 15 as the msb
logic [15:0] m_ac;
logic [15:0] m_at;
logic [15:0] m_ar;
logic [15:0] m_ic;
logic m_wzi;

// expected values for the cycle in progress
logic [15:0] e_a;
logic [15:0] e_w;
logic [15:0] e_ddt;
logic [15:0] e_f;
logic [15:0] e_dad;
logic e_carry;
logic e_s1;
logic e_zs;

task automatic clear_state();
	m_ac = '0;
	m_at = '0;
	m_ar = '0;
	m_ic = '0;
	m_wzi = 1'b0;
endtask

task automatic predict_outputs();
	logic [15:0] irv;
	logic [15:0] lv;
	logic ext_bit;
	irv = ir;
	lv = l;

	// A bus source followed by the three blanking fields
	case (ctl.a_sel)
		a_l: e_a = lv;
		a_ar: e_a = m_ar;
		a_ic: e_a = m_ic;
		default: e_a = {lv[7:0], irv[7:0]};
	endcase
	if (ctl.blank_a[0])
		e_a = e_a & 16'h00ff;
	if (ctl.blank_a[1])
		e_a = e_a & 16'hff3f;
	if (ctl.blank_a[2])
		e_a = e_a & 16'hffc0;

	case (ctl.w_sel)
		w_ir: e_w = ir;
		w_kl: e_w = kl;
		w_rdt: e_w = rdt;
		w_swap: e_w = m_ac >> 8;
		w_ki: e_w = ki;
		w_at: e_w = m_at;
		w_ac: e_w = m_ac;
		default: e_w = e_a;
	endcase
	if (ctl.blank_hi)
		e_w = e_w & 16'h00ff;
	if (ctl.blank_lo)
		e_w = e_w & 16'hff00;
	e_ddt = ctl.w_dt ? e_w : 16'h0000;

	// carry is the no-borrow flag for subtraction
	e_carry = 1'b0;
	case (ctl.op)
		op_add: {e_carry, e_f} = {1'b0, e_a} + {1'b0, m_ac} + 17'(ctl.carry_in);
		op_sub: begin
			e_f = e_a - m_ac;
			e_carry = (e_a >= m_ac);
		end
		op_and: e_f = e_a & m_ac;
		op_or: e_f = e_a | m_ac;
		op_xor: e_f = e_a ^ m_ac;
		op_pass_a: e_f = e_a;
		op_inc_a: begin
			e_f = e_a + 16'd1;
			e_carry = (e_a == 16'hffff);
		end
		default: begin
			e_f = e_a - 16'd1;
			e_carry = (e_a != 16'h0000);
		end
	endcase

	case (ctl.ext)
		ext_minus_one: ext_bit = !e_a[15];
		ext_plus_one: ext_bit = e_a[15];
		ext_sum: ext_bit = e_a[15] ^ m_ac[15];
		default: ext_bit = !(e_a[15] ^ m_ac[15]);
	endcase
	e_s1 = ext_bit ^ e_carry;
	e_zs = (e_f == 16'h0000) && !e_s1;

	e_dad = (ctl.ar_ad ? m_ar : 16'h0000) | (ctl.ic_ad ? m_ic : 16'h0000);
endtask

// register updates at the coming edge from this cycle's predictions
task automatic advance_state();
	if (ctl.w_ac)
		m_ac = e_w;
	if (ctl.wzi_load)
		m_wzi = e_zs;
	if (ctl.at_load)
		m_at = e_f;
	else if (ctl.at_shift)
		m_at = {ctl.at_sin, m_at[15:1]};
	if (ctl.w_ar)
		m_ar = e_w;
	else if (ctl.ar_step4)
		m_ar = m_ar - 16'd4;
	else if (ctl.ar_inc)
		m_ar = m_ar + 16'd1;
	if (ctl.w_ic)
		m_ic = e_w;
	else if (ctl.ic_inc)
		m_ic = m_ic + 16'd1;
endtask

`endif

/* tb_pa.sv */
`timescale 1ns/10ps

module tb_pa import pa_pkg::*; ();

	localparam int n_reset = 1;
	localparam int n_wbus = 200;
	localparam int n_alu = 400;
	localparam int n_at = 200;
	localparam int n_addr = 300;
	localparam int n_ex = 150;
	localparam int total_cycles = 2 + n_reset + n_wbus + n_alu + n_at + n_addr + n_ex;

	// stimulus kinds
	localparam int k_wbus = 0;
	localparam int k_alu = 1;
	localparam int k_at = 2;
	localparam int k_addr = 3;
	localparam int k_ex = 4;
	localparam int k_reset = 5;

	logic strob;
	logic rst;
	pa_ctl_t ctl;
	word_t ir;
	word_t ki;
	word_t rdt;
	word_t kl;
	word_t l;
	logic exx_sel;
	logic axy;
	word_t w;
	word_t ddt;
	word_t dad;
	pa_flags_t flags;

	logic [31:0] lfsr;
	int errors;
	int tests_run;
	int tests_failed;

	`include "tb_pa_model.svh"

	pa_top i_dut (
		.strob, .rst, .ctl, .ir, .ki, .rdt, .kl, .l, .exx_sel, .axy,
		.w, .ddt, .dad, .flags
	);

	initial begin
		strob = 1'b0;
		forever #50 strob = ~strob;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] random_word();
		logic [31:0] r;
		r = lfsr_bits(16);
		return r[15:0];
	endfunction

	function automatic logic coin_flip();
		logic [31:0] r;
		r = lfsr_bits(1);
		return r[0];
	endfunction

	task automatic drive_inputs(input int kind);
		pa_ctl_t c;
		logic [31:0] raw;
		raw = lfsr_bits($bits(pa_ctl_t));
		c = raw[$bits(pa_ctl_t)-1:0];
		// the control unit keeps these pairs exclusive
		if (c.at_load && c.at_shift)
			c.at_shift = 1'b0;
		if (c.ar_inc && c.ar_step4)
			c.ar_inc = 1'b0;
		if (kind != k_addr && kind != k_ex) begin
			c.w_ar = 1'b0;
			c.w_ic = 1'b0;
			c.ar_inc = 1'b0;
			c.ar_step4 = 1'b0;
			c.ic_inc = 1'b0;
		end
		case (kind)
			k_wbus: c.wzi_load = 1'b0;
			k_alu: begin
				c.at_load = 1'b0;
				c.at_shift = 1'b0;
			end
			k_at: begin
				c.w_sel = w_at;
				c.blank_hi = 1'b0;
				c.blank_lo = 1'b0;
				c.w_ac = 1'b0;
			end
			k_addr: begin
				c.at_load = 1'b0;
				c.at_shift = 1'b0;
				c.w_ac = 1'b0;
			end
			k_ex: begin
				c.w_ar = 1'b0;
				c.w_ic = 1'b0;
				c.at_shift = 1'b0;
			end
			default: begin
				c = '0;
				c.ar_ad = 1'b1;
				c.ic_ad = 1'b1;
			end
		endcase
		ctl = c;
		if (kind != k_reset) begin
			ir = random_word();
			ki = random_word();
			rdt = random_word();
			kl = random_word();
			l = random_word();
			exx_sel = coin_flip();
			axy = coin_flip();
		end
		// now and then put the address itself on the keys to hit zga
		if (kind == k_addr && lfsr_bits(2) == 0) begin
			predict_outputs();
			kl = e_dad;
		end
	endtask

	task automatic compare_word(input string sig, input logic [15:0] exp,
			input logic [15:0] act);
		if (act !== exp) begin
			$display("Fail t=%0t %s expected %h actual %h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic expect_bit(input string sig, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail t=%0t %s expected %b actual %b", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_outputs();
		predict_outputs();
		compare_word("w", e_w, w);
		compare_word("ddt", e_ddt, ddt);
		compare_word("dad", e_dad, dad);
		expect_bit("s0", e_f[15], flags.s0);
		expect_bit("carry", e_carry, flags.carry);
		expect_bit("s_1", e_s1, flags.s_1);
		expect_bit("zs", e_zs, flags.zs);
		expect_bit("wzi", m_wzi, flags.wzi);
		expect_bit("arz", m_ar[15:8] != 8'h00, flags.arz);
		expect_bit("zga", e_dad == kl, flags.zga);
		expect_bit("at15", m_at[0], flags.at15);
		expect_bit("exx", exx_sel ? e_a[0] : e_a[15], flags.exx);
		expect_bit("exy", axy ? m_at[0] : e_a[15], flags.exy);
	endtask

	// sample late in the cycle and let the edge commit the writes
	task automatic step_cycle();
		#40;
		check_outputs();
		advance_state();
		@(posedge strob);
		#5;
	endtask

	task automatic run_test(input string name, input int cycles, input int kind);
		int errs_before;
		errs_before = errors;
		for (int i = 0; i < cycles; i++) begin
			drive_inputs(kind);
			step_cycle();
		end
		tests_run++;
		if (errors != errs_before)
			tests_failed++;
		$display("test %-8s %0d cycles, %0d mismatches", name, cycles, errors - errs_before);
	endtask

	initial begin
		#((total_cycles + 20) * 100);
		$display("watchdog expired before the tests completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		lfsr = 32'h05911823;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		ctl = '0;
		ir = '0;
		ki = '0;
		rdt = '0;
		kl = '0;
		l = '0;
		exx_sel = 1'b0;
		axy = 1'b0;
		clear_state();
		repeat (2) @(posedge strob);
		#5;
		rst = 1'b0;

		run_test("reset", n_reset, k_reset);
		run_test("w_bus", n_wbus, k_wbus);
		run_test("alu", n_alu, k_alu);
		run_test("at", n_at, k_at);
		run_test("addr", n_addr, k_addr);
		run_test("exx_exy", n_ex, k_ex);

		$display("%0d tests, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
pa_pkg.sv
pa_w_mux.sv
pa_a_mux.sv
pa_alu.sv
pa_at_reg.sv
pa_accum.sv
pa_addr_regs.sv
pa_top.sv
tb_pa.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_pa
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
